/* filelist.f */
+incdir+hdl
hdl/soc_pkg.sv
hdl/block_ram.sv
hdl/ahb_addr_decoder.sv
hdl/ahb_ram_slave.sv
hdl/key_event_slave.sv
hdl/ahb_resp_mux.sv
hdl/ahb_soc_top.sv
tests/tb_ahb_soc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the AHB subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
    -f filelist.f \
    --top-module tb_ahb_soc

./obj_dir/Vtb_ahb_soc | tee "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* tests/tb_ahb_soc.sv */
`timescale 1ns/10ps
`default_nettype none
`include "soc_params.svh"

module tb_ahb_soc
    import soc_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;

    logic                   clk;
    logic                   RSTn;
    ahb_addr_u              haddr;
    htrans_e                htrans;
    hsize_e                 hsize;
    logic                   hwrite;
    logic [`SOC_DATA_W-1:0] hwdata;
    logic [`SOC_KEY_W-1:0]  key_pulse;
    wire                    hready;
    wire [`SOC_DATA_W-1:0]  hrdata;
    wire hresp_e            hresp;
    wire                    key_irq;

    // Stimulus table, one transfer per entry
    string                  t_name[$];
    logic [`SOC_ADDR_W-1:0] t_addr[$];
    logic                   t_write[$];
    hsize_e                 t_size[$];
    logic [`SOC_DATA_W-1:0] t_wdata[$];
    logic [`SOC_KEY_W-1:0]  t_pulse[$];
    logic                   t_chk_data[$];
    logic [`SOC_DATA_W-1:0] t_exp_data[$];
    hresp_e                 t_exp_resp[$];
    int                     t_exp_waits[$];
    logic                   t_chk_irq[$];
    logic                   t_exp_irq[$];

    // Reference models
    logic [`SOC_DATA_W-1:0] ref_mem [`SOC_RAM_WORDS];
    logic [`SOC_KEY_W-1:0]  ref_keys;

    integer seed;
    int     n_pass;
    int     n_fail;
    logic   test_bad;
    logic   table_ready = 1'b0;

    ahb_soc_top DUT (
        .clk       (clk),
        .RSTn      (RSTn),
        .haddr     (haddr),
        .htrans    (htrans),
        .hsize     (hsize),
        .hwrite    (hwrite),
        .hwdata    (hwdata),
        .key_pulse (key_pulse),
        .hready    (hready),
        .hrdata    (hrdata),
        .hresp     (hresp),
        .key_irq   (key_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------------------------
    // Table construction and expected values
    // ----------------------------------------------------------
    // Byte at lane addr[1:0], halfword in the half picked by addr[1]
    function automatic logic [3:0] lanes_of(input hsize_e size, input logic [1:0] low);
        logic [3:0] m;
        m = 4'b0000;
        for (int b = 0; b < 4; b++) begin
            if (size == WORD) m[b] = 1'b1;
            else if (size == HALF) m[b] = (b / 2 == int'(low[1]));
            else m[b] = (b == int'(low));
        end
        return m;
    endfunction

    task automatic add_entry(input string name, input logic [31:0] addr, input logic write,
                             input hsize_e size, input logic [31:0] wdata,
                             input logic [15:0] pulse);
        logic [9:0]  word;
        logic [3:0]  lanes;
        logic        chk_data;
        logic [31:0] exp_data;
        hresp_e      exp_resp;
        int          exp_waits;
        logic        chk_irq;
        logic        exp_irq;
        word      = addr[11:2];
        chk_data  = 1'b0;
        exp_data  = '0;
        exp_resp  = OKAY;
        exp_waits = 0;
        chk_irq   = 1'b0;
        exp_irq   = 1'b0;
        // Pulse is latched before this entry's data phase
        ref_keys  = ref_keys | pulse;
        if (addr[31:28] == `SOC_REGION_RAM) begin
            lanes = lanes_of(size, addr[1:0]);
            if (write) begin
                for (int b = 0; b < 4; b++) begin
                    if (lanes[b]) ref_mem[word][8*b +: 8] = wdata[8*b +: 8];
                end
            end else begin
                chk_data  = 1'b1;
                exp_data  = ref_mem[word];
                exp_waits = -1;
            end
        end else if (addr[31:28] == `SOC_REGION_KEY) begin
            chk_data = !write;
            exp_data = (addr[5:2] == 4'd0) ? {16'h0, ref_keys} : 32'h0;
            chk_irq  = 1'b1;
            exp_irq  = |ref_keys;
            if (write && addr[5:2] == 4'd0) ref_keys = ref_keys & ~wdata[15:0];
        end else begin
            exp_resp  = ERROR;
            exp_waits = 1;
        end
        t_name.push_back(name);
        t_addr.push_back(addr);
        t_write.push_back(write);
        t_size.push_back(size);
        t_wdata.push_back(wdata);
        t_pulse.push_back(pulse);
        t_chk_data.push_back(chk_data);
        t_exp_data.push_back(exp_data);
        t_exp_resp.push_back(exp_resp);
        t_exp_waits.push_back(exp_waits);
        t_chk_irq.push_back(chk_irq);
        t_exp_irq.push_back(exp_irq);
    endtask

    task automatic build_table();
        ref_keys = '0;
        add_entry("key_rd_after_reset", 32'h4000_0000, 1'b0, WORD, 32'h0, 16'h0);
        add_entry("ram_wr_first",       32'h0000_0000, 1'b1, WORD, $random(seed), 16'h0);
        add_entry("ram_wr_mid",         32'h0000_0104, 1'b1, WORD, $random(seed), 16'h0);
        add_entry("ram_wr_last",        32'h0000_0FFC, 1'b1, WORD, $random(seed), 16'h0);
        add_entry("ram_rd_first",       32'h0000_0000, 1'b0, WORD, 32'h0, 16'h0);
        add_entry("ram_rd_mid",         32'h0000_0104, 1'b0, WORD, 32'h0, 16'h0);
        add_entry("ram_rd_last",        32'h0000_0FFC, 1'b0, WORD, 32'h0, 16'h0);
        // Word index wraps, 0x1008 lands on word 2
        add_entry("ram_wr_wrap",        32'h0000_1008, 1'b1, WORD, $random(seed), 16'h0);
        add_entry("ram_rd_wrap",        32'h0000_0008, 1'b0, WORD, 32'h0, 16'h0);
        add_entry("ram_wr_word_40",     32'h0000_0040, 1'b1, WORD, $random(seed), 16'h0);
        add_entry("ram_wr_byte_41",     32'h0000_0041, 1'b1, BYTE, $random(seed), 16'h0);
        add_entry("ram_wr_half_42",     32'h0000_0042, 1'b1, HALF, $random(seed), 16'h0);
        add_entry("ram_rd_merged_40",   32'h0000_0040, 1'b0, WORD, 32'h0, 16'h0);
        add_entry("ram_wr_word_80",     32'h0000_0080, 1'b1, WORD, $random(seed), 16'h0);
        add_entry("ram_wr_half_80",     32'h0000_0080, 1'b1, HALF, $random(seed), 16'h0);
        add_entry("ram_wr_byte_83",     32'h0000_0083, 1'b1, BYTE, $random(seed), 16'h0);
        add_entry("ram_rd_merged_80",   32'h0000_0080, 1'b0, WORD, 32'h0, 16'h0);
        add_entry("ram_wr_raw",         32'h0000_0200, 1'b1, WORD, $random(seed), 16'h0);
        add_entry("ram_rd_raw",         32'h0000_0200, 1'b0, WORD, 32'h0, 16'h0);
        add_entry("unmapped_rd",        32'h2000_0010, 1'b0, WORD, 32'h0, 16'h0);
        add_entry("unmapped_wr",        32'h8000_0000, 1'b1, WORD, $random(seed), 16'h0);
        add_entry("ram_rd_after_err",   32'h0000_0104, 1'b0, WORD, 32'h0, 16'h0);
        add_entry("key_pulse_a",        32'h4000_0000, 1'b0, WORD, 32'h0, 16'h0011);
        add_entry("key_pulse_b",        32'h4000_0000, 1'b0, WORD, 32'h0, 16'h0300);
        add_entry("key_rd_reg1",        32'h4000_0004, 1'b0, WORD, 32'h0, 16'h8000);
        add_entry("key_clr_part",       32'h4000_0000, 1'b1, WORD, 32'h0000_0110, 16'h0);
        add_entry("key_rd_after_clr",   32'h4000_0000, 1'b0, WORD, 32'h0, 16'h0);
        add_entry("key_clr_all",        32'h4000_0000, 1'b1, WORD, 32'hFFFF_FFFF, 16'h0);
        // Pulse lands on the same edge as the clear above
        add_entry("key_pulse_wins",     32'h4000_0000, 1'b0, WORD, 32'h0, 16'h0004);
        add_entry("key_clr_last",       32'h4000_0000, 1'b1, WORD, 32'h0000_0004, 16'h0);
        add_entry("key_rd_empty",       32'h4000_0000, 1'b0, WORD, 32'h0, 16'h0);
    endtask

    // ----------------------------------------------------------
    // Bus master
    // ----------------------------------------------------------
    task automatic drive_addr(input int k);
        haddr     <= t_addr[k];
        htrans    <= NONSEQ;
        hsize     <= t_size[k];
        hwrite    <= t_write[k];
        key_pulse <= t_pulse[k];
    endtask

    task automatic drive_idle();
        haddr     <= '0;
        htrans    <= IDLE;
        hsize     <= WORD;
        hwrite    <= 1'b0;
        key_pulse <= '0;
    endtask

    // Returns at the falling edge before the edge that ends the data phase
    task automatic wait_ready(output int waits, output hresp_e first_resp,
                              output logic [31:0] rdata, output hresp_e resp,
                              output logic irq);
        waits = 0;
        @(negedge clk);
        first_resp = hresp;
        while (hready !== 1'b1) begin
            waits++;
            @(posedge clk);
            key_pulse <= '0;
            @(negedge clk);
        end
        rdata = hrdata;
        resp  = hresp;
        irq   = key_irq;
    endtask

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s %s expected %h actual %h", name, what, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_bad) begin
            n_fail++;
        end else begin
            n_pass++;
            $display("[PASS] %s", name);
        end
    endtask

    task automatic check_entry(input int k, input int waits, input hresp_e first_resp,
                               input logic [31:0] rdata, input hresp_e resp, input logic irq);
        test_bad = 1'b0;
        if (t_chk_data[k]) check_value(t_name[k], "hrdata", t_exp_data[k], rdata);
        check_value(t_name[k], "hresp", 32'(t_exp_resp[k]), 32'(resp));
        if (t_exp_waits[k] >= 0) begin
            check_value(t_name[k], "wait cycles", 32'(t_exp_waits[k]), 32'(waits));
        end
        if (t_exp_resp[k] == ERROR) begin
            check_value(t_name[k], "first cycle hresp", 32'(ERROR), 32'(first_resp));
        end
        if (t_chk_irq[k]) check_value(t_name[k], "key_irq", 32'(t_exp_irq[k]), 32'(irq));
        finish_test(t_name[k]);
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        int          waits;
        hresp_e      first_resp;
        hresp_e      resp;
        logic [31:0] rdata;
        logic        irq;
        seed      = 32'h770fb2c9;
        n_pass    = 0;
        n_fail    = 0;
        RSTn      <= 1'b0;
        hwdata    <= '0;
        drive_idle();
        build_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        RSTn <= 1'b1;
        @(negedge clk);
        test_bad = 1'b0;
        check_value("reset_state", "hready", 32'd1, 32'(hready));
        check_value("reset_state", "hresp", 32'(OKAY), 32'(hresp));
        check_value("reset_state", "key_irq", 32'd0, 32'(key_irq));
        finish_test("reset_state");

        // Address of entry k overlaps the data phase of entry k-1
        @(posedge clk);
        drive_addr(0);
        wait_ready(waits, first_resp, rdata, resp, irq);
        for (int k = 0; k < t_name.size(); k++) begin
            @(posedge clk);
            if (k + 1 < t_name.size()) drive_addr(k + 1);
            else drive_idle();
            hwdata <= t_wdata[k];
            wait_ready(waits, first_resp, rdata, resp, irq);
            check_entry(k, waits, first_resp, rdata, resp, irq);
        end
        @(posedge clk);
        drive_idle();

        $display("Tests run: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog, 20 cycles per table entry plus reset
    initial begin
        wait (table_ready === 1'b1);
        #((t_name.size() + RESET_CYCLES) * 20 * CLK_PERIOD);
        $display("Timeout: the bus transfers did not complete in the allowed time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/ahb_soc_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "soc_params.svh"

module ahb_soc_top
    import soc_pkg::*;
(
    input  wire                    clk,
    input  wire                    RSTn,
    input  wire ahb_addr_u         haddr,
    input  wire htrans_e           htrans,
    input  wire hsize_e            hsize,
    input  wire                    hwrite,
    input  wire [`SOC_DATA_W-1:0]  hwdata,
    input  wire [`SOC_KEY_W-1:0]   key_pulse,
    output wire                    hready,
    output wire [`SOC_DATA_W-1:0]  hrdata,
    output wire hresp_e            hresp,
    output wire                    key_irq
);

    wire                   sel_ram;
    wire                   sel_key;
    wire slave_sel_e       data_sel;
    wire                   ram_ready;
    wire [`SOC_DATA_W-1:0] ram_rdata;
    wire [`SOC_DATA_W-1:0] key_rdata;

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------
    ahb_addr_decoder u_decoder (
        .clk       (clk),
        .RSTn      (RSTn),
        .haddr     (haddr),
        .htrans    (htrans),
        .hready    (hready),
        .sel_ram   (sel_ram),
        .sel_key   (sel_key),
        .data_sel  (data_sel)
    );

    // ----------------------------------------------------------
    // Slaves
    // ----------------------------------------------------------
    ahb_ram_slave u_ram (
        .clk       (clk),
        .RSTn      (RSTn),
        .sel_ram   (sel_ram),
        .haddr     (haddr),
        .htrans    (htrans),
        .hsize     (hsize),
        .hwrite    (hwrite),
        .hwdata    (hwdata),
        .hready    (hready),
        .ram_ready (ram_ready),
        .ram_rdata (ram_rdata)
    );

    key_event_slave u_key (
        .clk       (clk),
        .RSTn      (RSTn),
        .sel_key   (sel_key),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hwdata    (hwdata),
        .hready    (hready),
        .key_pulse (key_pulse),
        .key_rdata (key_rdata),
        .key_irq   (key_irq)
    );

    // Response side, also the bus HREADY
    ahb_resp_mux u_resp (
        .clk       (clk),
        .RSTn      (RSTn),
        .data_sel  (data_sel),
        .ram_ready (ram_ready),
        .ram_rdata (ram_rdata),
        .key_rdata (key_rdata),
        .hready    (hready),
        .hrdata    (hrdata),
        .hresp     (hresp)
    );

endmodule

`default_nettype wire

/* hdl/ahb_resp_mux.sv */
`timescale 1ns/10ps
`default_nettype none
`include "soc_params.svh"

module ahb_resp_mux
    import soc_pkg::*;
(
    input  wire                    clk,
    input  wire                    RSTn,
    input  wire slave_sel_e        data_sel,
    input  wire                    ram_ready,
    input  wire [`SOC_DATA_W-1:0]  ram_rdata,
    input  wire [`SOC_DATA_W-1:0]  key_rdata,
    output logic                   hready,
    output logic [`SOC_DATA_W-1:0] hrdata,
    output hresp_e                 hresp
);

    logic err_2nd;

    // ----------------------------------------------------------
    // Default slave, two-cycle ERROR
    // ----------------------------------------------------------
    // Low in the first error cycle, high in the second
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            err_2nd <= 1'b0;
        end else begin
            err_2nd <= (data_sel == SEL_ERR) && !err_2nd;
        end
    end

    // ----------------------------------------------------------
    // Data phase routing
    // ----------------------------------------------------------
    always_comb begin
        hrdata = '0;
        hready = 1'b1;
        hresp  = OKAY;
        case (data_sel)
            SEL_RAM: begin
                hrdata = ram_rdata;
                hready = ram_ready;
            end
            SEL_KEY: begin
                hrdata = key_rdata;
            end
            SEL_ERR: begin
                hready = err_2nd;
                hresp  = ERROR;
            end
            default: begin
                // Idle, nothing to return
                hrdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/key_event_slave.sv */
`timescale 1ns/10ps
`default_nettype none
`include "soc_params.svh"

module key_event_slave
    import soc_pkg::*;
(
    input  wire                    clk,
    input  wire                    RSTn,
    input  wire                    sel_key,
    input  wire ahb_addr_u         haddr,
    input  wire htrans_e           htrans,
    input  wire                    hwrite,
    input  wire [`SOC_DATA_W-1:0]  hwdata,
    input  wire                    hready,
    input  wire [`SOC_KEY_W-1:0]   key_pulse,
    output logic [`SOC_DATA_W-1:0] key_rdata,
    output logic                   key_irq
);

    logic                  reg0_hit;
    logic                  hit_q;
    logic                  write_q;
    logic [`SOC_KEY_W-1:0] clr_mask;
    logic [`SOC_KEY_W-1:0] key_reg;

    assign reg0_hit = sel_key && ((htrans == NONSEQ) || (htrans == SEQ))
                      && (haddr.key_view.reg_idx == 4'd0);

    // ----------------------------------------------------------
    // Address phase capture
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            hit_q   <= 1'b0;
            write_q <= 1'b0;
        end else if (hready) begin
            hit_q   <= reg0_hit;
            write_q <= hwrite;
        end
    end

    // ----------------------------------------------------------
    // Sticky event register
    // ----------------------------------------------------------
    // Write-one-to-clear at the end of the data phase
    assign clr_mask = (hit_q && write_q && hready) ? hwdata[`SOC_KEY_W-1:0] : '0;

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            key_reg <= '0;
        end else begin
            // New pulse beats a clear on the same edge
            key_reg <= (key_reg & ~clr_mask) | key_pulse;
        end
    end

    assign key_rdata = hit_q ? {{(`SOC_DATA_W-`SOC_KEY_W){1'b0}}, key_reg} : '0;
    assign key_irq   = |key_reg;

endmodule

`default_nettype wire

/* hdl/ahb_ram_slave.sv */
`timescale 1ns/10ps
`default_nettype none
`include "soc_params.svh"

module ahb_ram_slave
    import soc_pkg::*;
(
    input  wire                    clk,
    input  wire                    RSTn,
    input  wire                    sel_ram,
    input  wire ahb_addr_u         haddr,
    input  wire htrans_e           htrans,
    input  wire hsize_e            hsize,
    input  wire                    hwrite,
    input  wire [`SOC_DATA_W-1:0]  hwdata,
    input  wire                    hready,
    output logic                   ram_ready,
    output wire [`SOC_DATA_W-1:0]  ram_rdata
);

    logic                   xfer;
    logic                   wr_pend;
    logic                   rd_stall;
    logic [`SOC_RAM_AW-1:0] dp_word;
    logic [3:0]             wr_be;
    logic [`SOC_RAM_AW-1:0] mem_addr;
    logic [3:0]             mem_we;

    // Byte lanes touched by a transfer
    function automatic logic [3:0] lane_mask(input hsize_e size, input logic [1:0] lane);
        case (size)
            BYTE:    lane_mask = 4'b0001 << lane;
            HALF:    lane_mask = lane[1] ? 4'b1100 : 4'b0011;
            default: lane_mask = 4'b1111;
        endcase
    endfunction

    assign xfer = sel_ram && ((htrans == NONSEQ) || (htrans == SEQ));

    // ----------------------------------------------------------
    // Write pending and read-after-write stall
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            wr_pend  <= 1'b0;
            rd_stall <= 1'b0;
        end else if (hready) begin
            wr_pend  <= xfer && hwrite;
            // Port is busy with the write, read must come back a cycle later
            rd_stall <= xfer && !hwrite && wr_pend;
        end else begin
            rd_stall <= 1'b0;
        end
    end

    // Word index and strobes of the data phase
    always_ff @(posedge clk) begin
        if (hready) begin
            dp_word <= haddr.ram_view.word;
            wr_be   <= lane_mask(hsize, haddr.ram_view.lane);
        end
    end

    // ----------------------------------------------------------
    // Memory port
    // ----------------------------------------------------------
    // Registered index while writing or re-presenting a stalled read,
    // live address otherwise
    assign mem_addr  = (wr_pend || rd_stall) ? dp_word : haddr.ram_view.word;
    assign mem_we    = wr_pend ? wr_be : 4'b0000;
    assign ram_ready = !rd_stall;

    block_ram #(
        .WORDS   (`SOC_RAM_WORDS)
    ) u_block_ram (
        .clk     (clk),
        .addr    (mem_addr),
        .wdata   (hwdata),
        .byte_we (mem_we),
        .rdata   (ram_rdata)
    );

endmodule

`default_nettype wire

/* hdl/ahb_addr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "soc_params.svh"

module ahb_addr_decoder
    import soc_pkg::*;
(
    input  wire             clk,
    input  wire             RSTn,
    input  wire ahb_addr_u  haddr,
    input  wire htrans_e    htrans,
    input  wire             hready,
    output logic            sel_ram,
    output logic            sel_key,
    output slave_sel_e      data_sel
);

    logic                     active;
    logic [`SOC_REGION_W-1:0] region;

    // ----------------------------------------------------------
    // Address phase decode
    // ----------------------------------------------------------
    assign active  = (htrans == NONSEQ) || (htrans == SEQ);
    assign region  = haddr.ram_view.region;
    assign sel_ram = (region == `SOC_REGION_RAM);
    assign sel_key = (region == `SOC_REGION_KEY);

    // ----------------------------------------------------------
    // Data phase owner, held through wait states
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            data_sel <= SEL_NONE;
        end else if (hready) begin
            if (!active) begin
                data_sel <= SEL_NONE;
            end else if (sel_ram) begin
                data_sel <= SEL_RAM;
            end else if (sel_key) begin
                data_sel <= SEL_KEY;
            end else begin
                // Unmapped region goes to the default slave
                data_sel <= SEL_ERR;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/block_ram.sv */
`timescale 1ns/10ps
`default_nettype none
`include "soc_params.svh"

module block_ram #(
    parameter int WORDS = 1024
) (
    input  wire                     clk,
    input  wire [$clog2(WORDS)-1:0] addr,
    input  wire [`SOC_DATA_W-1:0]   wdata,
    input  wire [3:0]               byte_we,
    output logic [`SOC_DATA_W-1:0]  rdata
);

    logic [`SOC_DATA_W-1:0] mem [WORDS];

    // Per-byte write, read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byte_we[i]) begin
                mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* hdl/soc_pkg.sv */
`default_nettype none
`include "soc_params.svh"

package soc_pkg;

    typedef enum logic [1:0] {
        IDLE   = `SOC_HTRANS_IDLE,
        BUSY   = `SOC_HTRANS_BUSY,
        NONSEQ = `SOC_HTRANS_NONSEQ,
        SEQ    = `SOC_HTRANS_SEQ
    } htrans_e;

    typedef enum logic [2:0] {
        BYTE = `SOC_HSIZE_BYTE,
        HALF = `SOC_HSIZE_HALF,
        WORD = `SOC_HSIZE_WORD
    } hsize_e;

    typedef enum logic {
        OKAY  = `SOC_HRESP_OKAY,
        ERROR = `SOC_HRESP_ERROR
    } hresp_e;

    // Owner of the current data phase
    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_RAM,
        SEL_KEY,
        SEL_ERR
    } slave_sel_e;

    // One HADDR, seen by the RAM as word/lane and by the key block as register
    typedef union packed {
        struct packed {
            logic [`SOC_REGION_W-1:0]                            region;
            logic [`SOC_ADDR_W-`SOC_REGION_W-`SOC_RAM_AW-3:0]    pad;
            logic [`SOC_RAM_AW-1:0]                              word;
            logic [1:0]                                          lane;
        } ram_view;
        struct packed {
            logic [`SOC_REGION_W-1:0]                            region;
            // 4-bit register index plus 2-bit lane below
            logic [`SOC_ADDR_W-`SOC_REGION_W-7:0]                pad;
            logic [3:0]                                          reg_idx;
            logic [1:0]                                          lane;
        } key_view;
    } ahb_addr_u;

endpackage

`default_nettype wire

/* hdl/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus and memory map
`define SOC_ADDR_W      32
`define SOC_DATA_W      32
`define SOC_REGION_W    4
`define SOC_RAM_AW      10
`define SOC_RAM_WORDS   (1 << `SOC_RAM_AW)
`define SOC_KEY_W       16
`define SOC_REGION_RAM  4'h0
`define SOC_REGION_KEY  4'h4

// AHB-Lite encodings
`define SOC_HTRANS_IDLE   2'b00
`define SOC_HTRANS_BUSY   2'b01
`define SOC_HTRANS_NONSEQ 2'b10
`define SOC_HTRANS_SEQ    2'b11
`define SOC_HSIZE_BYTE    3'b000
`define SOC_HSIZE_HALF    3'b001
`define SOC_HSIZE_WORD    3'b010
`define SOC_HRESP_OKAY    1'b0
`define SOC_HRESP_ERROR   1'b1

`endif
